/* design/lsu_pkg.sv */
// Load/store unit definitions
`default_nettype none

package lsu_pkg;

  ////////////////////
  // Widths
  ////////////////////

  typedef logic [31:0] word_t;    // Data or address word
  typedef logic [3:0]  be_t;      // One enable per byte lane
  typedef logic [1:0]  offset_t;  // Byte offset within a word
  typedef logic [1:0]  size_t;    // Access size code
  typedef logic [1:0]  cnt_t;     // Outstanding access count

  ////////////////////
  // Size codes
  ////////////////////

  // Same encoding as the funct3 low bits of RISC-V loads and stores
  localparam size_t SIZE_BYTE = 2'd0;  // lb, lbu, sb
  localparam size_t SIZE_HALF = 2'd1;  // lh, lhu, sh
  localparam size_t SIZE_WORD = 2'd2;  // lw, sw

  ////////////////////
  // Bus depth
  ////////////////////

  // Granted accesses allowed without a response
  // Also the depth of the writeback control queue
  localparam int unsigned MAX_OUTSTANDING = 2;

endpackage

`default_nettype wire

/* design/lsu_if.sv */
// Load/store unit internal interfaces
`default_nettype none
`timescale 1ns/10ps

// Aligned request towards the bus
interface lsu_req_if;
  import lsu_pkg::*;

  word_t   addr;    // Byte address, next word for a second half
  be_t     be;      // Byte enables of this access
  word_t   wdata;   // Store data rotated into its lanes
  offset_t offset;  // Raw offset of the first byte

  modport source (output addr, be, wdata, offset);
  modport sink   (input  addr, be, wdata, offset);
endinterface

// Response side control and result
interface lsu_wb_if;
  import lsu_pkg::*;

  size_t   size;        // Size of the access being answered
  logic    sext;        // Sign extension wanted
  offset_t offset;      // Raw offset of that access
  logic    last;        // Response completes the instruction
  logic    first_half;  // Response is the first half of a split
  logic    resp_valid;  // Bus response this cycle
  word_t   rdata_ext;   // Realigned, extended load data
  logic    err;         // Bus error of the whole instruction

  modport control (
    output size, sext, offset, last, first_half, resp_valid
  );
  modport datapath (
    input  size, sext, offset, last, first_half, resp_valid,
    output rdata_ext, err
  );
endinterface

`default_nettype wire

/* design/lsu_req_align.sv */
// Load/store request alignment
`default_nettype none
`timescale 1ns/10ps

module lsu_req_align (
  input  lsu_pkg::word_t operand_a_i,   // Base register
  input  lsu_pkg::word_t operand_b_i,   // Immediate offset
  input  lsu_pkg::word_t store_data_i,  // Register value to store
  input  lsu_pkg::size_t size_i,
  input  logic           second_half_i, // Second access of a split
  lsu_req_if.source      req
);
  import lsu_pkg::*;

  word_t          addr;        // Full byte address
  offset_t        offset;
  be_t            be_base;     // Enables for offset zero
  logic [7:0]     be_wide;     // Enables across two words
  logic [63:0]    wdata_wide;  // Doubled store data for rotation

  ////////////////////
  // Address
  ////////////////////

  assign addr   = operand_a_i + operand_b_i;
  assign offset = addr[1:0];

  // Second half starts at the next word boundary
  assign req.addr   = second_half_i ? ({addr[31:2], 2'b00} + 32'd4) : addr;
  assign req.offset = offset;

  ////////////////////
  // Byte enables
  ////////////////////

  always_comb begin
    case (size_i)
      SIZE_BYTE: be_base = 4'b0001;
      SIZE_HALF: be_base = 4'b0011;
      default:   be_base = 4'b1111;  // Word, unused code too
    endcase
  end

  // Shift into an eight lane window
  // Low word holds the first access, high word what spills over
  assign be_wide = {4'b0000, be_base} << offset;

  assign req.be = second_half_i ? be_wide[7:4] : be_wide[3:0];

  ////////////////////
  // Store data
  ////////////////////

  // Rotate left by the offset in bytes
  // Bytes pushed past lane 3 wrap into lane 0 for the second half
  assign wdata_wide = {store_data_i, store_data_i} << (8 * offset);
  assign req.wdata  = wdata_wide[63:32];

endmodule

`default_nettype wire

/* design/lsu_ctrl.sv */
// Load/store unit controller
`default_nettype none
`timescale 1ns/10ps

module lsu_ctrl (
  input  logic           clk,
  input  logic           rst_n,
  // Execute side
  input  logic           valid_0_i,
  output logic           ready_0_o,
  input  logic           we_i,
  input  lsu_pkg::size_t size_i,
  input  logic           sext_i,
  output logic           second_half_o,
  output logic           busy_o,
  // Writeback side
  output logic           valid_1_o,
  // Bus
  output logic           data_req_o,
  input  logic           data_gnt_i,
  output lsu_pkg::word_t data_addr_o,
  output logic           data_we_o,
  output lsu_pkg::be_t   data_be_o,
  output lsu_pkg::word_t data_wdata_o,
  input  logic           data_rvalid_i,
  // Internal
  lsu_req_if.sink        req,
  lsu_wb_if.control      wb
);
  import lsu_pkg::*;

  cnt_t    cnt_q;       // Outstanding accesses
  cnt_t    next_cnt;
  logic    count_up;    // Request granted
  logic    count_down;  // Response received
  logic    split_q;     // Second half pending on the bus
  logic    split_0;     // Current request is the first of two
  logic    wr_ptr_q;    // Queue write slot
  logic    rd_ptr_q;    // Queue slot of the oldest access
  logic    last_head;

  // Per access writeback control, one slot per open access
  size_t   size_q   [MAX_OUTSTANDING];
  logic    sext_q   [MAX_OUTSTANDING];
  offset_t offset_q [MAX_OUTSTANDING];
  logic    last_q   [MAX_OUTSTANDING];

  ////////////////////
  // Split decision
  ////////////////////

  always_comb begin
    split_0 = 1'b0;
    if (valid_0_i && !split_q) begin
      if (size_i == SIZE_WORD && req.offset != 2'b00) split_0 = 1'b1;  // Any unaligned word
      if (size_i == SIZE_HALF && req.offset == 2'b11) split_0 = 1'b1;  // Half crossing a word
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_0_i) begin
      split_q <= 1'b0;               // Next instruction starts unsplit
    end else if (count_up) begin
      split_q <= split_0;            // Set after first half, cleared after second
    end
  end

  assign second_half_o = split_q;

  ////////////////////
  // Bus request
  ////////////////////

  // No path from rvalid to req, a full window waits a cycle
  assign data_req_o   = valid_0_i && (cnt_q < MAX_OUTSTANDING);
  assign data_addr_o  = req.addr;
  assign data_we_o    = we_i;
  assign data_be_o    = req.be;
  assign data_wdata_o = req.wdata;

  // Execute stage moves on with the last grant of the instruction
  assign ready_0_o = !valid_0_i || (count_up && !split_0);

  assign busy_o = (cnt_q != '0) || data_req_o;

  ////////////////////
  // Outstanding count
  ////////////////////

  assign count_up   = data_req_o && data_gnt_i;
  assign count_down = data_rvalid_i;

  always_comb begin
    next_cnt = cnt_q;
    if (count_up && !count_down) next_cnt = cnt_q + cnt_t'(1);
    if (!count_up && count_down) next_cnt = cnt_q - cnt_t'(1);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= '0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      cnt_q <= next_cnt;
      if (count_up)   wr_ptr_q <= !wr_ptr_q;
      if (count_down) rd_ptr_q <= !rd_ptr_q;
    end
  end

  ////////////////////
  // Writeback control
  ////////////////////

  always_ff @(posedge clk) begin
    if (count_up) begin
      size_q[wr_ptr_q]   <= size_i;
      sext_q[wr_ptr_q]   <= sext_i;
      offset_q[wr_ptr_q] <= req.offset;
      last_q[wr_ptr_q]   <= !split_0;  // First half of a split is not last
    end
  end

  // Responses come in order, so the oldest slot is answered
  assign last_head = last_q[rd_ptr_q];

  assign wb.size       = size_q[rd_ptr_q];
  assign wb.sext       = sext_q[rd_ptr_q];
  assign wb.offset     = offset_q[rd_ptr_q];
  assign wb.last       = last_head;
  assign wb.resp_valid = data_rvalid_i;
  assign wb.first_half = data_rvalid_i && !last_head;

  assign valid_1_o = data_rvalid_i && last_head;  // One pulse per instruction

endmodule

`default_nettype wire

/* design/lsu_rdata_align.sv */
// Load data realignment
`default_nettype none
`timescale 1ns/10ps

module lsu_rdata_align (
  input  logic           clk,
  input  logic           rst_n,
  input  lsu_pkg::word_t data_rdata_i,
  input  logic           data_err_i,
  lsu_wb_if.datapath     wb
);
  import lsu_pkg::*;

  word_t        rdata_q;      // First half data
  logic         err_q;        // First half error
  logic         have_first_q; // First half stored, next response joins it
  word_t [1:0]  joined;       // High word is the newest response
  logic [63:0]  shifted;
  word_t        aligned;
  word_t        rdata_ext;

  ////////////////////
  // First half store
  ////////////////////

  always_ff @(posedge clk) begin
    if (wb.first_half) begin
      rdata_q <= data_rdata_i;
      err_q   <= data_err_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      have_first_q <= 1'b0;
    end else if (wb.resp_valid) begin
      have_first_q <= !wb.last;  // Held until the last half arrives
    end
  end

  ////////////////////
  // Realign
  ////////////////////

  // Unsplit: same word twice so bytes wrap into the low lanes
  always_comb begin
    joined[1] = data_rdata_i;
    joined[0] = have_first_q ? rdata_q : data_rdata_i;
  end

  assign shifted = joined >> (8 * wb.offset);
  assign aligned = shifted[31:0];

  ////////////////////
  // Sign extension
  ////////////////////

  always_comb begin
    case (wb.size)
      SIZE_BYTE: rdata_ext = {{24{wb.sext && aligned[7]}}, aligned[7:0]};
      SIZE_HALF: rdata_ext = {{16{wb.sext && aligned[15]}}, aligned[15:0]};
      default:   rdata_ext = aligned;  // Word, no extension
    endcase
  end

  assign wb.rdata_ext = rdata_ext;

  // Error of either half fails the instruction
  assign wb.err = data_err_i || (have_first_q && err_q);

endmodule

`default_nettype wire

/* design/lsu_top.sv */
// Load/store unit top level
`default_nettype none
`timescale 1ns/10ps

module lsu_top (
  input  logic           clk,
  input  logic           rst_n,

  // Execute stage
  input  logic           valid_0_i,
  output logic           ready_0_o,
  input  lsu_pkg::word_t operand_a_i,
  input  lsu_pkg::word_t operand_b_i,
  input  lsu_pkg::word_t store_data_i,
  input  logic           we_i,
  input  lsu_pkg::size_t size_i,
  input  logic           sext_i,

  // Writeback stage
  output logic           valid_1_o,
  output lsu_pkg::word_t rdata_1_o,
  output logic           err_1_o,

  // Status
  output logic           busy_o,

  // OBI data bus
  output logic           data_req_o,
  input  logic           data_gnt_i,
  output lsu_pkg::word_t data_addr_o,
  output logic           data_we_o,
  output lsu_pkg::be_t   data_be_o,
  output lsu_pkg::word_t data_wdata_o,
  input  logic           data_rvalid_i,
  input  lsu_pkg::word_t data_rdata_i,
  input  logic           data_err_i
);

  logic second_half;  // Split in its second address phase

  lsu_req_if req_if ();
  lsu_wb_if  wb_if ();

  ////////////////////
  // Request path
  ////////////////////

  lsu_req_align i_req_align (
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .store_data_i  (store_data_i),
    .size_i        (size_i),
    .second_half_i (second_half),
    .req           (req_if.source)
  );

  lsu_ctrl i_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_0_i     (valid_0_i),
    .ready_0_o     (ready_0_o),
    .we_i          (we_i),
    .size_i        (size_i),
    .sext_i        (sext_i),
    .second_half_o (second_half),
    .busy_o        (busy_o),
    .valid_1_o     (valid_1_o),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .data_rvalid_i (data_rvalid_i),
    .req           (req_if.sink),
    .wb            (wb_if.control)
  );

  ////////////////////
  // Response path
  ////////////////////

  lsu_rdata_align i_rdata_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_rdata_i (data_rdata_i),
    .data_err_i   (data_err_i),
    .wb           (wb_if.datapath)
  );

  assign rdata_1_o = wb_if.rdata_ext;  // Valid with valid_1_o only
  assign err_1_o   = wb_if.err;

endmodule

`default_nettype wire

/* verif/lsu_properties.sv */
// Bus handshake assertions
`default_nettype none
`timescale 1ns/10ps

module lsu_properties (
  input logic           clk,
  input logic           rst_n,
  input logic           req_i,
  input logic           gnt_i,
  input lsu_pkg::word_t addr_i,
  input logic           we_i,
  input lsu_pkg::be_t   be_i,
  input lsu_pkg::word_t wdata_i,
  input logic           rvalid_i,
  input logic           valid_1_i,
  input lsu_pkg::cnt_t  cnt_i
);
  import lsu_pkg::*;

  int unsigned fail_cnt = 0;  // Failed assertions so far

  ////////////////////
  // OBI request
  ////////////////////

  // Request held with its fields until granted
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req_i && !gnt_i |=> req_i && $stable(addr_i) && $stable(we_i)
                        && $stable(be_i) && $stable(wdata_i))
    else begin
      fail_cnt++;
      $error("bus request dropped or changed before grant");
    end

  cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_i <= cnt_t'(MAX_OUTSTANDING))
    else begin
      fail_cnt++;
      $error("outstanding count above limit");
    end

  // Result only in a response cycle, and only for an access still counted as open
  valid_resp: assert property (@(posedge clk) disable iff (!rst_n)
    valid_1_i |-> rvalid_i && (cnt_i != '0))
    else begin
      fail_cnt++;
      $error("valid_1_o without an open data_rvalid_i response");
    end

endmodule

bind lsu_ctrl lsu_properties i_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_i     (data_req_o),
  .gnt_i     (data_gnt_i),
  .addr_i    (data_addr_o),
  .we_i      (data_we_o),
  .be_i      (data_be_o),
  .wdata_i   (data_wdata_o),
  .rvalid_i  (data_rvalid_i),
  .valid_1_i (valid_1_o),
  .cnt_i     (cnt_q)
);

`default_nettype wire

/* verif/lsu_tb.sv */
// Load/store unit testbench
`default_nettype none
`timescale 1ns/10ps

module lsu_tb;
  import lsu_pkg::*;

  localparam int REC_WORDS  = 9;                // Fields per trace record
  localparam int TRACE_LEN  = 32 * REC_WORDS;
  localparam int WAIT_LIMIT = 200;              // Cycles before a wait gives up

  logic  clk = 1'b0;
  logic  rst_n;
  logic  valid_0_i;
  logic  ready_0_o;
  word_t operand_a_i;
  word_t operand_b_i;
  word_t store_data_i;
  logic  we_i;
  size_t size_i;
  logic  sext_i;
  logic  valid_1_o;
  word_t rdata_1_o;
  logic  err_1_o;
  logic  busy_o;
  logic  data_req_o;
  logic  data_gnt_i = 1'b0;
  word_t data_addr_o;
  logic  data_we_o;
  be_t   data_be_o;
  word_t data_wdata_o;
  logic  data_rvalid_i = 1'b0;
  word_t data_rdata_i = '0;
  logic  data_err_i = 1'b0;

  word_t       trace [0:TRACE_LEN-1];  // Raw trace records
  word_t       mem [0:63];             // Bus memory, 256 bytes mirrored
  word_t       addr_q [$];             // Expected bus addresses in order
  word_t       exp_data_q [$];
  logic        exp_err_q [$];
  logic        exp_chk_q [$];          // Loads only compare data
  word_t       resp_data_q [$];        // Responses waiting for rvalid
  logic        resp_err_q [$];
  int unsigned resp_due_q [$];
  int unsigned cycle = 0;
  int unsigned gnt_delay = 0;          // Cycles before next grant
  int unsigned out_cnt = 0;            // Granted, no response yet

  always #10 clk = ~clk;               // 20 ns period

  lsu_top i_dut (.*);

  ////////////////////
  // Checks
  ////////////////////

  task automatic check(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_run(input string what);
    $display("%s at %0t ns", what, $time);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic check_idle(input string when);
    @(posedge clk);
    check({"data_req_o ", when}, data_req_o, 0);
    check({"busy_o ", when}, busy_o, 0);
    check({"ready_0_o ", when}, ready_0_o, 1);
    check({"valid_1_o ", when}, valid_1_o, 0);
  endtask

  ////////////////////
  // Bus memory model
  ////////////////////

  always @(posedge clk) begin
    logic [5:0] idx;
    if (rst_n) begin
      cycle++;
      if (data_rvalid_i) begin             // Response taken this cycle
        void'(resp_data_q.pop_front());
        void'(resp_err_q.pop_front());
        void'(resp_due_q.pop_front());
        out_cnt--;
      end
      if (valid_1_o) begin
        if (exp_data_q.size() == 0) fail_run("valid_1_o with no instruction open");
        check("err_1_o", err_1_o, exp_err_q[0]);
        if (exp_chk_q[0] && !exp_err_q[0]) check("rdata_1_o", rdata_1_o, exp_data_q[0]);
        void'(exp_data_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(exp_chk_q.pop_front());
      end
      if (data_req_o && data_gnt_i) begin
        if (addr_q.size() == 0) fail_run("bus request with no access expected");
        check("data_addr_o", data_addr_o, addr_q.pop_front());
        idx = data_addr_o[7:2];
        if (data_we_o) begin
          for (int k = 0; k < 4; k++) begin
            if (data_be_o[k]) mem[idx][8*k +: 8] = data_wdata_o[8*k +: 8];  // Byte lanes
          end
        end
        resp_data_q.push_back(mem[idx]);
        resp_err_q.push_back(data_addr_o[12]);  // Error region at bit 12
        resp_due_q.push_back(cycle + $urandom_range(1, 3));
        out_cnt++;
        gnt_delay = $urandom_range(0, 3);
      end else if (data_req_o && gnt_delay != 0) begin
        gnt_delay--;                       // Stalled request
      end
      if (out_cnt > MAX_OUTSTANDING) check("outstanding accesses", out_cnt, MAX_OUTSTANDING);
    end
  end

  // Grant and responses change on the falling edge
  always @(negedge clk) begin
    if (i_dut.i_ctrl.i_props.fail_cnt != 0) fail_run("an assertion in lsu_properties failed");
    data_gnt_i = rst_n && (gnt_delay == 0);
    if (resp_due_q.size() != 0 && resp_due_q[0] <= cycle + 1) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = resp_data_q[0];
      data_err_i    = resp_err_q[0];
    end else begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
      data_err_i    = 1'b0;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic issue(input int b);
    word_t addr;
    size_t sz;
    logic  split;
    sz    = size_t'(trace[b+2]);
    addr  = trace[b+4] + trace[b+5];
    split = (sz == SIZE_WORD && addr[1:0] != 2'd0) || (sz == SIZE_HALF && addr[1:0] == 2'd3);
    addr_q.push_back(addr);
    if (split) addr_q.push_back({addr[31:2], 2'b00} + 32'd4);  // Next word
    exp_data_q.push_back(trace[b+7]);
    exp_err_q.push_back(trace[b+8][0]);
    exp_chk_q.push_back(!trace[b+1][0]);
    valid_0_i    = 1'b1;
    we_i         = trace[b+1][0];
    size_i       = sz;
    sext_i       = trace[b+3][0];
    operand_a_i  = trace[b+4];
    operand_b_i  = trace[b+5];
    store_data_i = trace[b+6];
    for (int n = 0; n <= WAIT_LIMIT; n++) begin
      @(posedge clk);
      if (ready_0_o) break;
      if (n == WAIT_LIMIT) fail_run("timeout waiting for ready_0_o");
    end
  endtask

  initial begin
    int b;
    void'($urandom(51823));
    rst_n        = 1'b0;
    valid_0_i    = 1'b0;
    operand_a_i  = '0;
    operand_b_i  = '0;
    store_data_i = '0;
    we_i         = 1'b0;
    size_i       = SIZE_WORD;
    sext_i       = 1'b0;
    for (int i = 0; i < 64; i++) mem[i] = 32'hc0de0000 | word_t'(i << 2);
    $readmemh("verif/lsu_trace.txt", trace);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_idle("after reset");
    b = 0;
    while (b < TRACE_LEN && trace[b] != 32'd2) begin
      if (trace[b] == 32'd0) begin
        mem[trace[b+4][7:2]] = trace[b+6];  // Preload
      end else begin
        @(negedge clk);
        issue(b);
      end
      b += REC_WORDS;
    end
    if (b >= TRACE_LEN) fail_run("trace has no end record");
    @(negedge clk);
    valid_0_i = 1'b0;
    for (int n = 0; n <= WAIT_LIMIT; n++) begin  // Drain open results
      @(negedge clk);
      if (exp_data_q.size() == 0 && out_cnt == 0) break;
      if (n == WAIT_LIMIT) fail_run("timeout waiting for the last results");
    end
    check_idle("after last operation");
    if (i_dut.i_ctrl.i_props.fail_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      fail_run("an assertion in lsu_properties failed");
    end
  end

endmodule

`default_nettype wire

/* verif/lsu_trace.txt */
// kind we size sext operand_a operand_b store_data expected_data expected_err
// kind 0 preload (operand_a is address, store_data is word), 1 operation, 2 end
0 0 0 0 00000004 00000000 00000000 00000000 0
0 0 0 0 00000008 00000000 00000000 00000000 0
0 0 0 0 00000020 00000000 8899aabb 00000000 0
0 0 0 0 00000024 00000000 01234567 00000000 0
0 0 0 0 00000028 00000000 f0e1d2c3 00000000 0
0 0 0 0 0000002c 00000000 7f80ff00 00000000 0
// aligned stores and loads
1 1 2 0 00000000 00000000 11223344 00000000 0
1 1 0 0 00000000 00000001 000000a5 00000000 0
1 0 2 0 00000000 00000000 00000000 1122a544 0
1 0 0 1 00000000 00000001 00000000 ffffffa5 0
1 0 0 0 00000001 00000000 00000000 000000a5 0
1 1 1 0 00000000 00000002 0000beef 00000000 0
1 0 1 1 00000000 00000002 00000000 ffffbeef 0
// split store and loads around it
1 1 2 0 00000004 00000002 12345678 00000000 0
1 0 2 0 00000004 00000002 00000000 12345678 0
1 0 2 0 00000004 00000000 00000000 56780000 0
// sign extension from preloaded words
1 0 0 1 00000020 00000002 00000000 ffffff99 0
1 0 1 1 0000002c 00000002 00000000 00007f80 0
// misaligned loads
1 0 2 0 00000020 00000001 00000000 678899aa 0
1 0 2 0 00000024 ffffffff 00000000 23456788 0
1 0 1 1 00000020 00000007 00000000 ffffc301 0
1 0 1 0 00000028 00000003 00000000 000000f0 0
1 0 2 0 00000028 00000002 00000000 ff00f0e1 0
// bus errors on one or both halves, then a clean load
1 0 2 0 00001000 00000000 00000000 00000000 1
1 0 2 0 00000ffc 00000002 00000000 00000000 1
1 0 2 0 00001ffc 00000002 00000000 00000000 1
1 0 2 0 00000020 00000000 00000000 8899aabb 0
2 0 0 0 00000000 00000000 00000000 00000000 0

/* vlog.f */
design/lsu_pkg.sv
design/lsu_if.sv
design/lsu_req_align.sv
design/lsu_ctrl.sv
design/lsu_rdata_align.sv
design/lsu_top.sv
verif/lsu_properties.sv
verif/lsu_tb.sv

/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := lsu_tb
FILELIST  := vlog.f
RUN_FLAGS := +verilator+error+limit+100
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qFx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
